//--- build.f
sc_dsp_pkg.sv
sc_regs_pkg.sv
sc_delay_corr.sv
sc_moving_sum.sv
sc_peak_detect.sv
sc_settings_regs.sv
sc_framer.sv
schmidl_cox_top.sv
tb_schmidl_cox.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_schmidl_cox -f build.f \
   && ./obj_dir/Vtb_schmidl_cox > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sc_delay_corr.sv
`timescale 1ns/10ps

module sc_delay_corr #(
   parameter int PERIOD = 16
) (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_adv,
   input  logic [2*sc_dsp_pkg::SAMPLE_W-1:0]    i_sample,
   output logic signed [sc_dsp_pkg::CORR_W-1:0] o_corr_i,
   output logic signed [sc_dsp_pkg::CORR_W-1:0] o_corr_q,
   output logic signed [sc_dsp_pkg::CORR_W-1:0] o_pow,
   output logic [2*sc_dsp_pkg::SAMPLE_W-1:0]    o_sample
);
   import sc_dsp_pkg::*;

   localparam int PTR_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

   logic [2*SAMPLE_W-1:0]        dline [PERIOD];
   logic [PTR_W-1:0]             wr_ptr;
   logic                         filled;
   logic [2*SAMPLE_W-1:0]        old_sample;
   logic signed [SAMPLE_W-1:0]   cur_i;
   logic signed [SAMPLE_W-1:0]   cur_q;
   logic signed [SAMPLE_W-1:0]   old_i;
   logic signed [SAMPLE_W-1:0]   old_q;
   logic signed [2*SAMPLE_W-1:0] p_ii;
   logic signed [2*SAMPLE_W-1:0] p_qq;
   logic signed [2*SAMPLE_W-1:0] p_qi;
   logic signed [2*SAMPLE_W-1:0] p_iq;
   logic signed [2*SAMPLE_W-1:0] p_pow_i;
   logic signed [2*SAMPLE_W-1:0] p_pow_q;

   // the delay line reads as zero until one full period has been written
   assign old_sample = filled ? dline[wr_ptr] : '0;

   assign cur_i = i_sample[2*SAMPLE_W-1:SAMPLE_W];
   assign cur_q = i_sample[SAMPLE_W-1:0];
   assign old_i = old_sample[2*SAMPLE_W-1:SAMPLE_W];
   assign old_q = old_sample[SAMPLE_W-1:0];

   // x * conj(y) = (xi*yi + xq*yq) + j(xq*yi - xi*yq)
   assign p_ii    = cur_i * old_i;
   assign p_qq    = cur_q * old_q;
   assign p_qi    = cur_q * old_i;
   assign p_iq    = cur_i * old_q;
   assign p_pow_i = cur_i * cur_i;
   assign p_pow_q = cur_q * cur_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         wr_ptr   <= '0;
         filled   <= 1'b0;
         o_corr_i <= '0;
         o_corr_q <= '0;
         o_pow    <= '0;
      end else if (i_adv) begin
         o_corr_i <= CORR_W'(p_ii) + CORR_W'(p_qq);
         o_corr_q <= CORR_W'(p_qi) - CORR_W'(p_iq);
         o_pow    <= CORR_W'(p_pow_i) + CORR_W'(p_pow_q);
         if (wr_ptr == PTR_W'(PERIOD - 1)) begin
            wr_ptr <= '0;
            filled <= 1'b1;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // oldest entry is read before it is overwritten in the same cycle
   always_ff @(posedge clk) begin
      if (i_adv) begin
         dline[wr_ptr] <= i_sample;
         o_sample      <= i_sample;
      end
   end

endmodule

//--- sc_dsp_pkg.sv
package sc_dsp_pkg;

   // one I or Q component
   localparam int SAMPLE_W = 16;

   // product of two components plus one bit for the sum of two products
   localparam int CORR_W = 2 * SAMPLE_W + 1;

   // moving sum width with room for windows of up to 256 samples
   localparam int SUM_W = CORR_W + 8;

   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      IN_REGION = 2'd1,
      REPORT    = 2'd2
   } det_state_t;

   typedef enum logic [1:0] {
      WAIT_TRIG = 2'd0,
      SKIP      = 2'd1,
      EMIT      = 2'd2
   } frm_state_t;

endpackage

//--- sc_framer.sv
`timescale 1ns/10ps

module sc_framer (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_adv,
   input  logic [2*sc_dsp_pkg::SAMPLE_W-1:0] i_sample,
   input  logic                              i_trig,
   input  logic [sc_regs_pkg::CNT_W-1:0]     i_peak_age,
   input  logic [sc_regs_pkg::CNT_W-1:0]     i_offset,
   input  logic [sc_regs_pkg::CNT_W-1:0]     i_sym_len,
   input  logic [sc_regs_pkg::CNT_W-1:0]     i_num_syms,
   output logic                              o_load,
   output logic [2*sc_dsp_pkg::SAMPLE_W-1:0] o_data,
   output logic                              o_last
);
   import sc_dsp_pkg::*;
   import sc_regs_pkg::*;

   frm_state_t            state;
   logic [2*SAMPLE_W-1:0] pipe_1;
   logic [2*SAMPLE_W-1:0] pipe_2;
   logic [CNT_W-1:0]      skip_cnt;
   logic [CNT_W-1:0]      samp_cnt;
   logic [CNT_W-1:0]      sym_cnt;
   logic [CNT_W:0]        skip_diff;
   logic                  skip_none;
   logic                  shape_ok;
   logic                  sym_end;
   logic                  frame_end;

   // two more stages line the sample up with the detector trigger
   always_ff @(posedge clk) begin
      if (i_adv) begin
         pipe_1 <= i_sample;
         pipe_2 <= pipe_1;
      end
   end

   assign skip_diff = {1'b0, i_offset} - {1'b0, i_peak_age};
   // offset already passed when the difference is zero or negative
   assign skip_none = skip_diff[CNT_W] || (skip_diff == '0);
   assign shape_ok  = (i_sym_len != '0) && (i_num_syms != '0);
   assign sym_end   = (samp_cnt == i_sym_len - 1'b1);
   assign frame_end = (sym_cnt == i_num_syms - 1'b1);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= WAIT_TRIG;
         skip_cnt <= '0;
         samp_cnt <= '0;
         sym_cnt  <= '0;
      end else if (i_adv) begin
         case (state)
            WAIT_TRIG: begin
               samp_cnt <= '0;
               sym_cnt  <= '0;
               if (i_trig && shape_ok) begin
                  if (skip_none) begin
                     state <= EMIT;
                  end else begin
                     skip_cnt <= skip_diff[CNT_W-1:0];
                     state    <= SKIP;
                  end
               end
            end
            SKIP: begin
               skip_cnt <= skip_cnt - 1'b1;
               if (skip_cnt == CNT_W'(1)) begin
                  state <= EMIT;
               end
            end
            EMIT: begin
               // new triggers are not looked at until the frame is done
               if (sym_end) begin
                  samp_cnt <= '0;
                  if (frame_end) begin
                     sym_cnt <= '0;
                     state   <= WAIT_TRIG;
                  end else begin
                     sym_cnt <= sym_cnt + 1'b1;
                  end
               end else begin
                  samp_cnt <= samp_cnt + 1'b1;
               end
            end
            default: begin
               state <= WAIT_TRIG;
            end
         endcase
      end
   end

   assign o_load = i_adv && (state == EMIT);
   assign o_data = pipe_2;
   assign o_last = (state == EMIT) && sym_end;

endmodule

//--- sc_moving_sum.sv
`timescale 1ns/10ps

module sc_moving_sum #(
   parameter int WIN_LEN = 32
) (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_adv,
   input  logic signed [sc_dsp_pkg::CORR_W-1:0] i_value,
   output logic signed [sc_dsp_pkg::SUM_W-1:0]  o_sum
);
   import sc_dsp_pkg::*;

   localparam int PTR_W = (WIN_LEN > 1) ? $clog2(WIN_LEN) : 1;
   // full window of CORR_W values without overflow
   localparam int ACC_W = CORR_W + PTR_W;

   logic signed [CORR_W-1:0] hist [WIN_LEN];
   logic [PTR_W-1:0]         wr_ptr;
   logic                     filled;
   logic signed [CORR_W-1:0] leaving;
   logic signed [ACC_W-1:0]  acc;

   // nothing leaves the window before it has filled once
   assign leaving = filled ? hist[wr_ptr] : '0;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         filled <= 1'b0;
         acc    <= '0;
      end else if (i_adv) begin
         acc <= acc + ACC_W'(i_value) - ACC_W'(leaving);
         if (wr_ptr == PTR_W'(WIN_LEN - 1)) begin
            wr_ptr <= '0;
            filled <= 1'b1;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_adv) begin
         hist[wr_ptr] <= i_value;
      end
   end

   // sign extend to the common sum width
   assign o_sum = SUM_W'(acc);

endmodule

//--- sc_peak_detect.sv
`timescale 1ns/10ps

module sc_peak_detect (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_adv,
   input  logic signed [sc_dsp_pkg::SUM_W-1:0]  i_sum_i,
   input  logic signed [sc_dsp_pkg::SUM_W-1:0]  i_sum_q,
   input  logic signed [sc_dsp_pkg::SUM_W-1:0]  i_sum_pow,
   input  logic [sc_regs_pkg::THRESH_W-1:0]     i_thresh,
   output logic                                 o_trig,
   output logic [sc_regs_pkg::CNT_W-1:0]        o_peak_age
);
   import sc_dsp_pkg::*;
   import sc_regs_pkg::*;

   localparam int MAG_W = SUM_W + 1;
   localparam int CMP_W = MAG_W + THRESH_W;

   det_state_t       state;
   logic [SUM_W-1:0] abs_i;
   logic [SUM_W-1:0] abs_q;
   logic [SUM_W-1:0] big;
   logic [SUM_W-1:0] small_abs;
   logic [SUM_W-1:0] pow_u;
   logic [MAG_W-1:0] mag;
   logic [MAG_W-1:0] max_mag;
   logic [CMP_W-1:0] lhs;
   logic [CMP_W-1:0] rhs;
   logic             above;

   assign abs_i = i_sum_i[SUM_W-1] ? -i_sum_i : i_sum_i;
   assign abs_q = i_sum_q[SUM_W-1] ? -i_sum_q : i_sum_q;
   // power sum never goes negative
   assign pow_u = i_sum_pow;

   // |z| ~ max + min/2
   assign big       = (abs_i > abs_q) ? abs_i : abs_q;
   assign small_abs = (abs_i > abs_q) ? abs_q : abs_i;
   assign mag       = MAG_W'(big) + MAG_W'(small_abs >> 1);

   // 256 * mag > thresh * power
   assign lhs   = {mag, {THRESH_W{1'b0}}};
   assign rhs   = CMP_W'(i_thresh) * CMP_W'(pow_u);
   assign above = (lhs > rhs);

   // age counts from the peak to the sample that follows the region end,
   // which is the first sample the framer sees after the trigger
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= IDLE;
         o_peak_age <= '0;
      end else if (i_adv) begin
         case (state)
            IDLE: begin
               if (above) begin
                  state      <= IN_REGION;
                  o_peak_age <= CNT_W'(1);
               end
            end
            IN_REGION: begin
               if (above && (mag > max_mag)) begin
                  o_peak_age <= CNT_W'(1);
               end else if (o_peak_age != '1) begin
                  o_peak_age <= o_peak_age + 1'b1;
               end
               if (!above) begin
                  state <= REPORT;
               end
            end
            REPORT: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_adv) begin
         if ((state == IDLE) || ((state == IN_REGION) && above && (mag > max_mag))) begin
            max_mag <= mag;
         end
      end
   end

   // held for exactly one accepted sample
   assign o_trig = (state == REPORT);

endmodule

//--- sc_regs_pkg.sv
package sc_regs_pkg;

   localparam int ADDR_W     = 8;
   localparam int SET_DATA_W = 32;

   // offset, symbol length and symbol count
   localparam int CNT_W = 16;

   // threshold is a fraction of 256
   localparam int THRESH_W = 8;

   typedef enum logic [ADDR_W-1:0] {
      ADDR_THRESH   = 8'h00,
      ADDR_OFFSET   = 8'h01,
      ADDR_SYM_LEN  = 8'h02,
      ADDR_NUM_SYMS = 8'h03
   } reg_addr_t;

   localparam logic [THRESH_W-1:0] THRESH_DEF   = 8'd128;
   localparam logic [CNT_W-1:0]    OFFSET_DEF   = 16'd0;
   localparam logic [CNT_W-1:0]    SYM_LEN_DEF  = 16'd64;
   localparam logic [CNT_W-1:0]    NUM_SYMS_DEF = 16'd2;

endpackage

//--- sc_settings_regs.sv
`timescale 1ns/10ps

module sc_settings_regs (
   input  logic                               clk,
   input  logic                               i_rst_n,
   input  logic                               i_set_stb,
   input  logic [sc_regs_pkg::ADDR_W-1:0]     i_set_addr,
   input  logic [sc_regs_pkg::SET_DATA_W-1:0] i_set_data,
   output logic [sc_regs_pkg::THRESH_W-1:0]   o_thresh,
   output logic [sc_regs_pkg::CNT_W-1:0]      o_offset,
   output logic [sc_regs_pkg::CNT_W-1:0]      o_sym_len,
   output logic [sc_regs_pkg::CNT_W-1:0]      o_num_syms
);
   import sc_regs_pkg::*;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_thresh   <= THRESH_DEF;
         o_offset   <= OFFSET_DEF;
         o_sym_len  <= SYM_LEN_DEF;
         o_num_syms <= NUM_SYMS_DEF;
      end else if (i_set_stb) begin
         // fields take the low bits of the write data
         case (reg_addr_t'(i_set_addr))
            ADDR_THRESH:   o_thresh   <= i_set_data[THRESH_W-1:0];
            ADDR_OFFSET:   o_offset   <= i_set_data[CNT_W-1:0];
            ADDR_SYM_LEN:  o_sym_len  <= i_set_data[CNT_W-1:0];
            ADDR_NUM_SYMS: o_num_syms <= i_set_data[CNT_W-1:0];
            default: begin
            end
         endcase
      end
   end

endmodule

//--- sc_trace.txt
# W addr data | S count tdata | E count tdata tlast | C outputs_so_far
# values in hex except counts, tdata has I in bits 31:16 and Q in bits 15:0
W 1 40
# uncorrelated lead-in, 16-sample blocks with signs + + - -
S 32 10000000
S 32 f0000000
C 0
# preamble of four periods
S 64 f0000000
# tail blocks + + - - + + - - + +
S 32 10000000
S 32 f0000000
S 32 10000000
S 32 f0000000
S 32 10000000
# frame starts 64 samples after the peak, two symbols of 64
E 17 10000000 0
E 32 f0000000 0
E 14 10000000 0
E 1 10000000 1
E 17 10000000 0
E 32 f0000000 0
E 14 10000000 0
E 1 10000000 1
C 128
# threshold 255, preamble with one flipped sample stays below it
W 0 ff
S 40 f0000000
S 1 10000000
S 23 f0000000
S 32 10000000
S 32 f0000000
C 128
# threshold 128, offset 0, three symbols of 16
W 0 80
W 1 0
W 2 10
W 3 3
S 64 f0000000
S 32 10000000
S 32 f0000000
E 15 10000000 0
E 1 10000000 1
E 8 10000000 0
E 7 f0000000 0
E 1 f0000000 1
E 15 f0000000 0
E 1 f0000000 1
C 176

//--- schmidl_cox_top.sv
`timescale 1ns/10ps

module schmidl_cox_top #(
   parameter int PERIOD  = 16,
   parameter int WIN_LEN = 32
) (
   input  logic                               clk,
   input  logic                               i_rst_n,
   input  logic                               i_set_stb,
   input  logic [sc_regs_pkg::ADDR_W-1:0]     i_set_addr,
   input  logic [sc_regs_pkg::SET_DATA_W-1:0] i_set_data,
   input  logic [2*sc_dsp_pkg::SAMPLE_W-1:0]  i_tdata,
   input  logic                               i_tvalid,
   output logic                               o_tready,
   output logic [2*sc_dsp_pkg::SAMPLE_W-1:0]  o_tdata,
   output logic                               o_tlast,
   output logic                               o_tvalid,
   input  logic                               i_tready
);
   import sc_dsp_pkg::*;
   import sc_regs_pkg::*;

   logic                     adv;
   logic                     out_valid;
   logic [THRESH_W-1:0]      thresh;
   logic [CNT_W-1:0]         offset;
   logic [CNT_W-1:0]         sym_len;
   logic [CNT_W-1:0]         num_syms;
   logic signed [CORR_W-1:0] corr_i;
   logic signed [CORR_W-1:0] corr_q;
   logic signed [CORR_W-1:0] pow;
   logic [2*SAMPLE_W-1:0]    dly_sample;
   logic signed [SUM_W-1:0]  sum_i;
   logic signed [SUM_W-1:0]  sum_q;
   logic signed [SUM_W-1:0]  sum_pow;
   logic                     trig;
   logic [CNT_W-1:0]         peak_age;
   logic                     frm_load;
   logic [2*SAMPLE_W-1:0]    frm_data;
   logic                     frm_last;

   // the whole datapath moves only when an input sample is accepted
   assign o_tready = !out_valid || i_tready;
   assign adv      = i_tvalid && o_tready;
   assign o_tvalid = out_valid;

   sc_settings_regs u_regs (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_thresh   (thresh),
      .o_offset   (offset),
      .o_sym_len  (sym_len),
      .o_num_syms (num_syms)
   );

   sc_delay_corr #(.PERIOD(PERIOD)) u_corr (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_adv    (adv),
      .i_sample (i_tdata),
      .o_corr_i (corr_i),
      .o_corr_q (corr_q),
      .o_pow    (pow),
      .o_sample (dly_sample)
   );

   sc_moving_sum #(.WIN_LEN(WIN_LEN)) u_sum_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_adv   (adv),
      .i_value (corr_i),
      .o_sum   (sum_i)
   );

   sc_moving_sum #(.WIN_LEN(WIN_LEN)) u_sum_q (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_adv   (adv),
      .i_value (corr_q),
      .o_sum   (sum_q)
   );

   sc_moving_sum #(.WIN_LEN(WIN_LEN)) u_sum_pow (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_adv   (adv),
      .i_value (pow),
      .o_sum   (sum_pow)
   );

   sc_peak_detect u_peak (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_adv      (adv),
      .i_sum_i    (sum_i),
      .i_sum_q    (sum_q),
      .i_sum_pow  (sum_pow),
      .i_thresh   (thresh),
      .o_trig     (trig),
      .o_peak_age (peak_age)
   );

   sc_framer u_framer (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_adv      (adv),
      .i_sample   (dly_sample),
      .i_trig     (trig),
      .i_peak_age (peak_age),
      .i_offset   (offset),
      .i_sym_len  (sym_len),
      .i_num_syms (num_syms),
      .o_load     (frm_load),
      .o_data     (frm_data),
      .o_last     (frm_last)
   );

   // when adv is high the register is empty or being drained this cycle
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         out_valid <= 1'b0;
      end else if (adv) begin
         out_valid <= frm_load;
      end else if (i_tready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (frm_load) begin
         o_tdata <= frm_data;
         o_tlast <= frm_last;
      end
   end

endmodule

//--- tb_schmidl_cox.sv
`timescale 1ns/10ps

module tb_schmidl_cox;
   import sc_dsp_pkg::*;
   import sc_regs_pkg::*;

   localparam int CLK_HALF = 2;
   localparam int WAIT_MAX = 500;

   logic                  clk;
   logic                  i_rst_n;
   logic                  i_set_stb;
   logic [ADDR_W-1:0]     i_set_addr;
   logic [SET_DATA_W-1:0] i_set_data;
   logic [2*SAMPLE_W-1:0] i_tdata;
   logic                  i_tvalid;
   logic                  o_tready;
   logic [2*SAMPLE_W-1:0] o_tdata;
   logic                  o_tlast;
   logic                  o_tvalid;
   logic                  i_tready;

   // commands in trace order, expected output samples in arrival order
   byte                   cmd_kind[$];
   int                    cmd_cnt[$];
   logic [31:0]           cmd_val[$];
   logic [31:0]           exp_data[$];
   logic                  exp_last[$];
   int                    recv_cnt = 0;

   schmidl_cox_top #(.PERIOD(16), .WIN_LEN(32)) i_dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_tdata    (i_tdata),
      .i_tvalid   (i_tvalid),
      .o_tready   (o_tready),
      .o_tdata    (o_tdata),
      .o_tlast    (o_tlast),
      .o_tvalid   (o_tvalid),
      .i_tready   (i_tready)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic report_failure(input string what);
      $display("failure at %0t ns: %s", $time, what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic load_trace();
      int          fd;
      int          n;
      int          cnt;
      int          last;
      int          rep;
      string       line;
      byte         kind;
      logic [31:0] val;
      fd = $fopen("sc_trace.txt", "r");
      assert (fd != 0) else report_failure("cannot open sc_trace.txt");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if ((n > 0) && (line.len() > 0)) begin
            kind = line.getc(0);
            cnt  = 0;
            val  = '0;
            last = 0;
            case (kind)
               "W": n = $sscanf(line, "W %h %h", cnt, val);
               "S": n = $sscanf(line, "S %d %h", cnt, val);
               "C": n = $sscanf(line, "C %d", cnt);
               "E": n = $sscanf(line, "E %d %h %d", cnt, val, last);
               default: n = 0;
            endcase
            if (kind == "E") begin
               for (rep = 0; rep < cnt; rep++) begin
                  exp_data.push_back(val);
                  exp_last.push_back(last != 0);
               end
            end else if (n > 0) begin
               cmd_kind.push_back(kind);
               cmd_cnt.push_back(cnt);
               cmd_val.push_back(val);
            end
         end
      end
      $fclose(fd);
   endtask

   // called and left on a falling edge
   task automatic write_reg(input int addr, input logic [31:0] data);
      i_tvalid   = 1'b0;
      i_set_stb  = 1'b1;
      i_set_addr = ADDR_W'(addr);
      i_set_data = data;
      @(negedge clk);
      i_set_stb  = 1'b0;
   endtask

   task automatic send_sample(input logic [31:0] data);
      int   waited;
      int   gaps;
      logic taken;
      gaps = $urandom_range(2);
      repeat (gaps) begin
         i_tvalid = 1'b0;
         @(negedge clk);
      end
      i_tdata  = data;
      i_tvalid = 1'b1;
      taken    = 1'b0;
      waited   = 0;
      while (!taken) begin
         #1;
         taken = o_tready;
         if (!taken) begin
            waited++;
            assert (waited < WAIT_MAX) else report_failure("o_tready stuck low on input");
         end
         @(negedge clk);
      end
   endtask

   // no loads happen without accepted input, so the count is final once drained
   task automatic check_count(input int total);
      int waited;
      i_tvalid = 1'b0;
      waited   = 0;
      while (o_tvalid) begin
         waited++;
         assert (waited < WAIT_MAX) else report_failure("output register never drained");
         @(negedge clk);
      end
      assert (recv_cnt == total) else report_mismatch("output sample count", 32'(recv_cnt),
                                                      32'(total));
   endtask

   initial begin : collector
      logic [31:0] want_data;
      logic        want_last;
      i_tready = 1'b0;
      forever begin
         @(negedge clk);
         // random back-pressure with ready low about one cycle in three
         i_tready = ($urandom_range(2) != 0);
         #1;
         if (o_tvalid && i_tready) begin
            assert (exp_data.size() > 0) else report_failure($sformatf(
               "output sample with none expected, detector in %s", i_dut.u_peak.state.name()));
            want_data = exp_data.pop_front();
            want_last = exp_last.pop_front();
            assert (o_tdata == want_data) else report_mismatch("o_tdata", o_tdata, want_data);
            assert (o_tlast == want_last) else report_mismatch("o_tlast", 32'(o_tlast),
                                                               32'(want_last));
            recv_cnt++;
         end
      end
   end

   initial begin : driver
      int k;
      int rep;
      int waited;
      void'($urandom(32'h96f3d17d));
      i_rst_n    = 1'b0;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_tdata    = '0;
      i_tvalid   = 1'b0;
      load_trace();
      repeat (8) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;
      waited  = 0;
      while (!o_tready) begin
         waited++;
         assert (waited < WAIT_MAX) else report_failure("o_tready low after reset");
         @(negedge clk);
      end
      assert (o_tvalid == 1'b0) else report_mismatch("o_tvalid", 32'(o_tvalid), 32'd0);
      for (k = 0; k < cmd_kind.size(); k++) begin
         case (cmd_kind[k])
            "W": write_reg(cmd_cnt[k], cmd_val[k]);
            "S": begin
               for (rep = 0; rep < cmd_cnt[k]; rep++) begin
                  send_sample(cmd_val[k]);
               end
            end
            "C": check_count(cmd_cnt[k]);
            default: report_failure("unknown command in trace");
         endcase
      end
      if (exp_data.size() != 0) begin
         report_failure("expected output samples never arrived");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule
